/* csrng.f */
hdl/csrng_pkg.sv
hdl/csrng_cmd_if.sv
hdl/csrng_cmd_stage.sv
hdl/csrng_cmd_arb.sv
hdl/csrng_state_db.sv
hdl/csrng_drbg.sv
hdl/csrng_reg_top.sv
hdl/csrng.sv
test/csrng_props.sv
test/csrng_tb.sv

/* hdl/csrng.sv */
/*
  Subsystem top level
  Command stages, arbiter, DRBG engine, state records, registers
*/

`timescale 1ns/1ps

module csrng import csrng_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_i,

  // Application ports
  input  logic       [NHwApps-1:0]     app_cmd_valid_i,
  output logic       [NHwApps-1:0]     app_cmd_ready_o,
  input  csrng_op_t  [NHwApps-1:0]     app_cmd_op_i,
  input  glen_t      [NHwApps-1:0]     app_cmd_glen_i,
  input  genbits_t   [NHwApps-1:0]     app_cmd_adata_i,
  output logic       [NHwApps-1:0]     app_bits_valid_o,
  output genbits_t   [NHwApps-1:0]     app_bits_o,
  input  logic       [NHwApps-1:0]     app_bits_ready_i,
  output logic       [NHwApps-1:0]     app_rsp_valid_o,
  output csrng_sts_t [NHwApps-1:0]     app_rsp_sts_o,

  // Entropy source
  output logic                         es_req_o,
  input  logic                         es_valid_i,
  input  genbits_t                     es_bits_i,

  // Register port
  input  logic                         reg_valid_i,
  input  logic                         reg_write_i,
  input  reg_addr_t                    reg_addr_i,
  input  reg_data_t                    reg_wdata_i,
  output reg_data_t                    reg_rdata_o,
  output logic                         reg_rvalid_o,

  output logic                         intr_cmd_done_o,
  output logic                         intr_cmd_err_o
);

  logic               enable;
  logic [NHwApps-1:0] rsp_err;
  app_id_t            grant_id;
  app_id_t            rd_id;
  genbits_t           rd_key;
  genbits_t           rd_ctr;
  logic               rd_inst;
  logic               wr_en;
  app_id_t            wr_id;
  genbits_t           wr_key;
  genbits_t           wr_ctr;
  logic               wr_inst;

  csrng_cmd_if stg_if [NHwApps] ();
  csrng_cmd_if eng_if ();

  //////////////////////////////////////////////////////////////////////
  // Command stages
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NHwApps; i++) begin : gen_stage
    csrng_cmd_stage u_stage (
      .clk_i,
      .rst_i,
      .enable_i     (enable),
      .cmd_valid_i  (app_cmd_valid_i[i]),
      .cmd_ready_o  (app_cmd_ready_o[i]),
      .cmd_op_i     (app_cmd_op_i[i]),
      .cmd_glen_i   (app_cmd_glen_i[i]),
      .cmd_adata_i  (app_cmd_adata_i[i]),
      .bits_valid_o (app_bits_valid_o[i]),
      .bits_o       (app_bits_o[i]),
      .bits_ready_i (app_bits_ready_i[i]),
      .rsp_valid_o  (app_rsp_valid_o[i]),
      .rsp_sts_o    (app_rsp_sts_o[i]),
      .eng          (stg_if[i])
    );

    assign rsp_err[i] = app_rsp_valid_o[i] & (app_rsp_sts_o[i] != StsOk);
  end

  csrng_cmd_arb u_arb (
    .clk_i,
    .rst_i,
    .stg        (stg_if),
    .eng        (eng_if),
    .grant_id_o (grant_id)
  );

  csrng_drbg u_drbg (
    .clk_i,
    .rst_i,
    .cmd        (eng_if),
    .grant_id_i (grant_id),
    .rd_id_o    (rd_id),
    .rd_key_i   (rd_key),
    .rd_ctr_i   (rd_ctr),
    .rd_inst_i  (rd_inst),
    .wr_en_o    (wr_en),
    .wr_id_o    (wr_id),
    .wr_key_o   (wr_key),
    .wr_ctr_o   (wr_ctr),
    .wr_inst_o  (wr_inst),
    .es_req_o,
    .es_valid_i,
    .es_bits_i
  );

  csrng_state_db u_state_db (
    .clk_i,
    .rst_i,
    .rd_id_i   (rd_id),
    .rd_key_o  (rd_key),
    .rd_ctr_o  (rd_ctr),
    .rd_inst_o (rd_inst),
    .wr_en_i   (wr_en),
    .wr_id_i   (wr_id),
    .wr_key_i  (wr_key),
    .wr_ctr_i  (wr_ctr),
    .wr_inst_i (wr_inst)
  );

  // Interrupt events from any application response
  csrng_reg_top u_reg (
    .clk_i,
    .rst_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_rvalid_o,
    .done_evt_i (|app_rsp_valid_o),
    .err_evt_i  (|rsp_err),
    .enable_o   (enable),
    .intr_cmd_done_o,
    .intr_cmd_err_o
  );

endmodule

/* hdl/csrng_cmd_arb.sv */
/*
  Round-robin arbiter from the command stages to the engine
  The granted stage keeps the engine until its command completes
*/

`timescale 1ns/1ps

module csrng_cmd_arb import csrng_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  csrng_cmd_if.engine stg [NHwApps],
  csrng_cmd_if.stage  eng,
  output app_id_t     grant_id_o
);

  logic [NHwApps-1:0] req_vld;
  logic [NHwApps-1:0] bits_rdy;
  csrng_op_t          req_op    [NHwApps];
  glen_t              req_glen  [NHwApps];
  genbits_t           req_adata [NHwApps];
  logic               lock_q;
  app_id_t            grant_q;
  app_id_t            rr_q;
  app_id_t            sel;

  //////////////////////////////////////////////////////////////////////
  // Per-stage routing
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NHwApps; i++) begin : gen_route
    assign req_vld[i]   = stg[i].req_valid;
    assign req_op[i]    = stg[i].req_op;
    assign req_glen[i]  = stg[i].req_glen;
    assign req_adata[i] = stg[i].req_adata;
    assign bits_rdy[i]  = stg[i].bits_ready;

    assign stg[i].req_ready  = ~lock_q & eng.req_ready & (sel == app_id_t'(i));
    assign stg[i].bits_valid = lock_q & eng.bits_valid & (grant_q == app_id_t'(i));
    assign stg[i].bits       = eng.bits;
    assign stg[i].done_valid = lock_q & eng.done_valid & (grant_q == app_id_t'(i));
    assign stg[i].done_sts   = eng.done_sts;
  end

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    sel   = rr_q;
    found = 1'b0;
    for (int k = 0; k < NHwApps; k++) begin
      idx = (int'(rr_q) + k) % NHwApps;
      if (!found && req_vld[idx]) begin
        sel   = app_id_t'(idx);
        found = 1'b1;
      end
    end
  end

  assign eng.req_valid  = ~lock_q & (|req_vld);
  assign eng.req_op     = req_op[sel];
  assign eng.req_glen   = req_glen[sel];
  assign eng.req_adata  = req_adata[sel];
  assign eng.bits_ready = lock_q & bits_rdy[grant_q];

  assign grant_id_o = lock_q ? grant_q : sel;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
      rr_q    <= '0;
    end else if (eng.req_valid && eng.req_ready) begin
      lock_q  <= 1'b1;
      grant_q <= sel;
      rr_q    <= app_id_t'((int'(sel) + 1) % NHwApps);
    end else if (lock_q && eng.done_valid) begin
      lock_q <= 1'b0;
    end
  end

endmodule

/* hdl/csrng_cmd_if.sv */
/*
  Command, bit and completion channels between a command stage
  and the engine side
*/

`timescale 1ns/1ps

interface csrng_cmd_if import csrng_pkg::*; ();

  // Command path
  logic       req_valid;
  logic       req_ready;
  csrng_op_t  req_op;
  glen_t      req_glen;
  genbits_t   req_adata;

  // Generated blocks
  logic       bits_valid;
  logic       bits_ready;
  genbits_t   bits;

  // Completion
  logic       done_valid;
  csrng_sts_t done_sts;

  modport stage (
    output req_valid, req_op, req_glen, req_adata, bits_ready,
    input  req_ready, bits_valid, bits, done_valid, done_sts
  );

  modport engine (
    input  req_valid, req_op, req_glen, req_adata, bits_ready,
    output req_ready, bits_valid, bits, done_valid, done_sts
  );

endinterface

/* hdl/csrng_cmd_stage.sv */
/*
  Per-application command stage
  Holds one command, rejects illegal ones locally, forwards the rest
*/

`timescale 1ns/1ps

module csrng_cmd_stage import csrng_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       enable_i,
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  input  csrng_op_t  cmd_op_i,
  input  glen_t      cmd_glen_i,
  input  genbits_t   cmd_adata_i,
  output logic       bits_valid_o,
  output genbits_t   bits_o,
  input  logic       bits_ready_i,
  output logic       rsp_valid_o,
  output csrng_sts_t rsp_sts_o,
  csrng_cmd_if.stage eng
);

  logic      full_q;
  logic      sent_q;
  csrng_op_t op_q;
  glen_t     glen_q;
  genbits_t  adata_q;
  logic      bad_op;
  logic      bad_len;

  // Only accept when idle and software has enabled the block
  assign cmd_ready_o = enable_i & ~full_q;

  assign bad_op  = (op_q == 2'd0);
  assign bad_len = (op_q == OpGen) && (glen_q == '0);

  assign eng.req_valid = full_q & ~sent_q & ~bad_op & ~bad_len;
  assign eng.req_op    = op_q;
  assign eng.req_glen  = glen_q;
  assign eng.req_adata = adata_q;

  // Block path to the application
  assign bits_valid_o   = eng.bits_valid;
  assign bits_o         = eng.bits;
  assign eng.bits_ready = bits_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q      <= 1'b0;
      sent_q      <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (cmd_valid_i && cmd_ready_o) begin
        full_q  <= 1'b1;
        op_q    <= cmd_op_i;
        glen_q  <= cmd_glen_i;
        adata_q <= cmd_adata_i;
      end else if (full_q && (bad_op || bad_len)) begin
        // Answered here, never reaches the arbiter
        full_q      <= 1'b0;
        rsp_valid_o <= 1'b1;
        rsp_sts_o   <= bad_op ? StsBadOp : StsBadLen;
      end else if (eng.done_valid) begin
        full_q      <= 1'b0;
        sent_q      <= 1'b0;
        rsp_valid_o <= 1'b1;
        rsp_sts_o   <= eng.done_sts;
      end else if (eng.req_valid && eng.req_ready) begin
        sent_q <= 1'b1;
      end
    end
  end

endmodule

/* hdl/csrng_drbg.sv */
/*
  DRBG engine
  Entropy fetch, block generation under back-pressure, record update
*/

`timescale 1ns/1ps

module csrng_drbg import csrng_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  csrng_cmd_if.engine  cmd,
  input  app_id_t      grant_id_i,
  output app_id_t      rd_id_o,
  input  genbits_t     rd_key_i,
  input  genbits_t     rd_ctr_i,
  input  logic         rd_inst_i,
  output logic         wr_en_o,
  output app_id_t      wr_id_o,
  output genbits_t     wr_key_o,
  output genbits_t     wr_ctr_o,
  output logic         wr_inst_o,
  output logic         es_req_o,
  input  logic         es_valid_i,
  input  genbits_t     es_bits_i
);

  drbg_state_e state_q;
  app_id_t     id_q;
  csrng_op_t   op_q;
  glen_t       cnt_q;
  genbits_t    adata_q;
  genbits_t    key_q;
  genbits_t    ctr_q;
  genbits_t    blk_q;
  logic        blk_vld_q;
  csrng_sts_t  sts_q;
  genbits_t    ctr_inc;

  // Stand-in for the block cipher, not cryptographic
  function automatic genbits_t mix(genbits_t key, genbits_t ctr);
    genbits_t x;
    x = key ^ ctr;
    return ((x << MixRot) | (x >> ($bits(genbits_t) - MixRot))) + ctr;
  endfunction

  assign ctr_inc = ctr_q + genbits_t'(1);

  assign cmd.req_ready  = (state_q == DrbgIdle);
  assign cmd.bits_valid = (state_q == DrbgGen) & blk_vld_q;
  assign cmd.bits       = blk_q;
  assign cmd.done_valid = (state_q == DrbgDone);
  assign cmd.done_sts   = sts_q;

  assign es_req_o = (state_q == DrbgEntropy);

  // Record of the app being granted
  assign rd_id_o   = grant_id_i;
  assign wr_en_o   = (state_q == DrbgUpdate);
  assign wr_id_o   = id_q;
  assign wr_key_o  = key_q;
  assign wr_ctr_o  = ctr_q;
  assign wr_inst_o = (op_q != OpUni);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= DrbgIdle;
      blk_vld_q <= 1'b0;
    end else begin
      case (state_q)
        DrbgIdle: begin
          if (cmd.req_valid) begin
            id_q    <= grant_id_i;
            op_q    <= cmd.req_op;
            cnt_q   <= cmd.req_glen;
            adata_q <= cmd.req_adata;
            key_q   <= rd_key_i;
            ctr_q   <= rd_ctr_i;
            sts_q   <= StsOk;
            if (cmd.req_op == OpIns) begin
              state_q <= DrbgEntropy;
            end else if (cmd.req_op == OpUni) begin
              key_q   <= '0;
              ctr_q   <= '0;
              state_q <= DrbgUpdate;
            end else if (!rd_inst_i) begin
              sts_q   <= StsNotInst;
              state_q <= DrbgDone;
            end else begin
              state_q <= DrbgGen;
            end
          end
        end
        DrbgEntropy: begin
          if (es_valid_i) begin
            key_q   <= es_bits_i ^ adata_q;
            ctr_q   <= '0;
            state_q <= DrbgUpdate;
          end
        end
        DrbgGen: begin
          if (!blk_vld_q) begin
            ctr_q     <= ctr_inc;
            blk_q     <= mix(key_q, ctr_inc);
            blk_vld_q <= 1'b1;
          end else if (cmd.bits_ready) begin
            blk_vld_q <= 1'b0;
            cnt_q     <= cnt_q - glen_t'(1);
            // Last block folds back into the key
            if (cnt_q == glen_t'(1)) begin
              key_q   <= key_q ^ blk_q;
              state_q <= DrbgUpdate;
            end
          end
        end
        DrbgUpdate: state_q <= DrbgDone;
        DrbgDone:   state_q <= DrbgIdle;
        default:    state_q <= DrbgIdle;
      endcase
    end
  end

endmodule

/* hdl/csrng_pkg.sv */
/*
  Shared definitions for the random bit generator subsystem
  Widths, command and status codes, register map, engine states
*/

package csrng_pkg;

  // Number of hardware applications
  localparam int NHwApps = 2;
  localparam int AppIdW = (NHwApps > 1) ? $clog2(NHwApps) : 1;

  typedef logic [AppIdW-1:0] app_id_t;

  //////////////////////////////////////////////////////////////////////
  // Commands and responses
  //////////////////////////////////////////////////////////////////////

  typedef logic [1:0] csrng_op_t;

  // Code 0 is reserved
  localparam csrng_op_t OpIns = 2'd1;
  localparam csrng_op_t OpGen = 2'd2;
  localparam csrng_op_t OpUni = 2'd3;

  // Generate length in 64-bit blocks
  typedef logic [3:0] glen_t;

  // Output block, also key, counter and entropy width
  typedef logic [63:0] genbits_t;

  typedef logic [1:0] csrng_sts_t;

  localparam csrng_sts_t StsOk      = 2'd0;
  localparam csrng_sts_t StsBadOp   = 2'd1;
  localparam csrng_sts_t StsBadLen  = 2'd2;
  localparam csrng_sts_t StsNotInst = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  localparam reg_addr_t RegCtrl       = 4'h0;
  localparam reg_addr_t RegIntrState  = 4'h4;
  localparam reg_addr_t RegIntrEnable = 4'h8;

  // Left rotate of the block mixing rule
  localparam int MixRot = 13;

  typedef enum logic [2:0] {
    DrbgIdle,
    DrbgEntropy,
    DrbgGen,
    DrbgUpdate,
    DrbgDone
  } drbg_state_e;

endpackage

/* hdl/csrng_reg_top.sv */
/*
  Software registers
  Enable, interrupt state (write 1 to clear), interrupt enable
*/

`timescale 1ns/1ps

module csrng_reg_top import csrng_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,
  input  logic      done_evt_i,
  input  logic      err_evt_i,
  output logic      enable_o,
  output logic      intr_cmd_done_o,
  output logic      intr_cmd_err_o
);

  logic       wr_en;
  logic       enable_q;
  logic [1:0] intr_state_q;
  logic [1:0] intr_en_q;
  logic [1:0] intr_clr;
  reg_data_t  rdata_d;

  assign wr_en    = reg_valid_i & reg_write_i;
  assign enable_o = enable_q;

  // New events win over a clear in the same cycle
  assign intr_clr = (wr_en && reg_addr_i == RegIntrState) ? reg_wdata_i[1:0] : 2'b00;

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      RegCtrl:       rdata_d[0]   = enable_q;
      RegIntrState:  rdata_d[1:0] = intr_state_q;
      RegIntrEnable: rdata_d[1:0] = intr_en_q;
      default:       rdata_d      = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q        <= 1'b0;
      intr_state_q    <= '0;
      intr_en_q       <= '0;
      reg_rvalid_o    <= 1'b0;
      intr_cmd_done_o <= 1'b0;
      intr_cmd_err_o  <= 1'b0;
    end else begin
      if (wr_en && reg_addr_i == RegCtrl) begin
        enable_q <= reg_wdata_i[0];
      end
      if (wr_en && reg_addr_i == RegIntrEnable) begin
        intr_en_q <= reg_wdata_i[1:0];
      end
      intr_state_q    <= (intr_state_q & ~intr_clr) | {err_evt_i, done_evt_i};
      reg_rvalid_o    <= reg_valid_i & ~reg_write_i;
      intr_cmd_done_o <= intr_state_q[0] & intr_en_q[0];
      intr_cmd_err_o  <= intr_state_q[1] & intr_en_q[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_valid_i && !reg_write_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

/* hdl/csrng_state_db.sv */
/*
  Instance state records
  Key, counter and instantiated flag per application
*/

`timescale 1ns/1ps

module csrng_state_db import csrng_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  app_id_t  rd_id_i,
  output genbits_t rd_key_o,
  output genbits_t rd_ctr_o,
  output logic     rd_inst_o,
  input  logic     wr_en_i,
  input  app_id_t  wr_id_i,
  input  genbits_t wr_key_i,
  input  genbits_t wr_ctr_i,
  input  logic     wr_inst_i
);

  genbits_t           key_q [NHwApps];
  genbits_t           ctr_q [NHwApps];
  logic [NHwApps-1:0] inst_q;

  // Combinational read
  assign rd_key_o  = key_q[rd_id_i];
  assign rd_ctr_o  = ctr_q[rd_id_i];
  assign rd_inst_o = inst_q[rd_id_i];

  // One record written per cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NHwApps; i++) begin
        key_q[i] <= '0;
        ctr_q[i] <= '0;
      end
      inst_q <= '0;
    end else if (wr_en_i) begin
      key_q[wr_id_i]  <= wr_key_i;
      ctr_q[wr_id_i]  <= wr_ctr_i;
      inst_q[wr_id_i] <= wr_inst_i;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the csrng testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csrng.f --top-module csrng_tb -o csrng_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/csrng_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0

/* test/csrng_props.sv */
/*
  Concurrent checks on the top-level handshakes, bound into csrng
*/

`timescale 1ns/1ps

module csrng_props import csrng_pkg::*; (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic     [NHwApps-1:0]   app_rsp_valid_o,
  input logic     [NHwApps-1:0]   app_bits_valid_o,
  input genbits_t [NHwApps-1:0]   app_bits_o,
  input logic     [NHwApps-1:0]   app_bits_ready_i,
  input logic                     es_req_o,
  input logic                     es_valid_i,
  input logic                     reg_valid_i,
  input logic                     reg_write_i,
  input logic                     reg_rvalid_o
);

  for (genvar i = 0; i < NHwApps; i++) begin : gen_app
    // Response is a single-cycle pulse
    rsp_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      app_rsp_valid_o[i] |=> !app_rsp_valid_o[i])
      else $error("app_rsp_valid_o longer than one cycle");

    // Block held until the application takes it
    bits_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      app_bits_valid_o[i] && !app_bits_ready_i[i] |=>
        app_bits_valid_o[i] && $stable(app_bits_o[i]))
      else $error("app_bits dropped or changed before acceptance");
  end

  es_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    es_req_o && !es_valid_i |=> es_req_o)
    else $error("es_req_o dropped before es_valid_i");

  rd_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    reg_valid_i && !reg_write_i |=> reg_rvalid_o)
    else $error("reg_rvalid_o missing one cycle after a read");

endmodule

/* test/csrng_tb.sv */
/*
  Directed testbench for the random bit generator subsystem
  Reference model of the DRBG rule, entropy responder, compare tasks
*/

`timescale 1ns/1ps

module csrng_tb import csrng_pkg::*; ();

  localparam int      WaitLimit = 1000;
  localparam app_id_t App0      = app_id_t'(0);
  localparam app_id_t App1      = app_id_t'(1);

  logic                         clk_i;
  logic                         rst_i;
  logic       [NHwApps-1:0]     app_cmd_valid_i;
  logic       [NHwApps-1:0]     app_cmd_ready_o;
  csrng_op_t  [NHwApps-1:0]     app_cmd_op_i;
  glen_t      [NHwApps-1:0]     app_cmd_glen_i;
  genbits_t   [NHwApps-1:0]     app_cmd_adata_i;
  logic       [NHwApps-1:0]     app_bits_valid_o;
  genbits_t   [NHwApps-1:0]     app_bits_o;
  logic       [NHwApps-1:0]     app_bits_ready_i;
  logic       [NHwApps-1:0]     app_rsp_valid_o;
  csrng_sts_t [NHwApps-1:0]     app_rsp_sts_o;
  logic                         es_req_o;
  logic                         es_valid_i;
  genbits_t                     es_bits_i;
  logic                         reg_valid_i;
  logic                         reg_write_i;
  reg_addr_t                    reg_addr_i;
  reg_data_t                    reg_wdata_i;
  reg_data_t                    reg_rdata_o;
  logic                         reg_rvalid_o;
  logic                         intr_cmd_done_o;
  logic                         intr_cmd_err_o;

  int          seed = 32'hd8852c96;
  int unsigned es_delay;
  genbits_t    es_word;

  // Reference model, one record per application
  genbits_t model_key  [NHwApps];
  genbits_t model_ctr  [NHwApps];
  logic     model_inst [NHwApps];

  csrng dut0 (.*);

  bind csrng csrng_props props0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .app_rsp_valid_o  (app_rsp_valid_o),
    .app_bits_valid_o (app_bits_valid_o),
    .app_bits_o       (app_bits_o),
    .app_bits_ready_i (app_bits_ready_i),
    .es_req_o         (es_req_o),
    .es_valid_i       (es_valid_i),
    .reg_valid_i      (reg_valid_i),
    .reg_write_i      (reg_write_i),
    .reg_rvalid_o     (reg_rvalid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Outputs are settled and inputs are driven 1 ns after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_bits(input string name, input genbits_t got, input genbits_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_sts(input string name, input csrng_sts_t got, input csrng_sts_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Rotate of key XOR counter, then add the counter
  function automatic genbits_t expected_block(input genbits_t key, input genbits_t ctr);
    genbits_t x;
    genbits_t rot;
    x   = key ^ ctr;
    rot = {x[63-MixRot:0], x[63:64-MixRot]};
    return rot + ctr;
  endfunction

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_valid_i = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    step();
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    reg_valid_i = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    step();
    reg_valid_i = 1'b0;
    if (!reg_rvalid_o) begin
      stop_run($sformatf("Register read of address %0h gave no rvalid one cycle later", addr));
    end
    data = reg_rdata_o;
  endtask

  task automatic wait_intr(input bit err);
    int cycles;
    cycles = 0;
    while (!(err ? intr_cmd_err_o : intr_cmd_done_o)) begin
      step();
      cycles++;
      if (cycles > WaitLimit) begin
        stop_run($sformatf("Timeout waiting for interrupt line (error line: %0d)", err));
      end
    end
  endtask

  task automatic send_cmd(input app_id_t app, input csrng_op_t op, input glen_t glen,
                          input genbits_t adata);
    int cycles;
    cycles = 0;
    app_cmd_valid_i[app] = 1'b1;
    app_cmd_op_i[app]    = op;
    app_cmd_glen_i[app]  = glen;
    app_cmd_adata_i[app] = adata;
    while (!app_cmd_ready_o[app]) begin
      step();
      cycles++;
      if (cycles > WaitLimit) begin
        stop_run($sformatf("Timeout waiting for command ready on app %0d", app));
      end
    end
    step();
    app_cmd_valid_i[app] = 1'b0;
  endtask

  // Issue one command, check every block and the status against the model
  task automatic run_cmd(input app_id_t app, input csrng_op_t op, input glen_t glen,
                         input genbits_t adata, input bit random_ready);
    genbits_t   exp_blocks[$];
    csrng_sts_t exp_sts;
    csrng_sts_t sts;
    int         nbits;
    int         cycles;
    bit         got;
    exp_sts = StsOk;
    if (op == 2'd0) begin
      exp_sts = StsBadOp;
    end else if (op == OpGen && glen == '0) begin
      exp_sts = StsBadLen;
    end else if (op == OpGen && !model_inst[app]) begin
      exp_sts = StsNotInst;
    end else if (op == OpGen) begin
      for (int k = 0; k < int'(glen); k++) begin
        model_ctr[app] = model_ctr[app] + 64'd1;
        exp_blocks.push_back(expected_block(model_key[app], model_ctr[app]));
      end
      model_key[app] = model_key[app] ^ exp_blocks[exp_blocks.size()-1];
    end else if (op == OpUni) begin
      model_key[app]  = '0;
      model_ctr[app]  = '0;
      model_inst[app] = 1'b0;
    end
    send_cmd(app, op, glen, adata);
    nbits  = 0;
    cycles = 0;
    got    = 1'b0;
    sts    = StsOk;
    while (!got) begin
      if (random_ready) begin
        app_bits_ready_i[app] = (($random(seed) & 3) != 0);
      end else begin
        app_bits_ready_i[app] = 1'b1;
      end
      // Valid and ready both high here means a transfer at the next edge
      if (app_bits_valid_o[app] && app_bits_ready_i[app]) begin
        if (nbits >= exp_blocks.size()) begin
          stop_run($sformatf("App %0d delivered a block that was not expected", app));
        end
        check_bits($sformatf("app_bits_o[%0d]", app), app_bits_o[app], exp_blocks[nbits]);
        nbits++;
      end
      if (app_rsp_valid_o[app]) begin
        got = 1'b1;
        sts = app_rsp_sts_o[app];
      end else begin
        step();
        cycles++;
        if (cycles > WaitLimit) begin
          stop_run($sformatf("Timeout waiting for the response on app %0d", app));
        end
      end
    end
    app_bits_ready_i[app] = 1'b0;
    check_sts($sformatf("app_rsp_sts_o[%0d]", app), sts, exp_sts);
    if (nbits != exp_blocks.size()) begin
      stop_run($sformatf("App %0d gave %0d blocks instead of %0d", app, nbits,
                         exp_blocks.size()));
    end
    // Seed is known only once the entropy word has been taken
    if (op == OpIns) begin
      model_key[app]  = es_word ^ adata;
      model_ctr[app]  = '0;
      model_inst[app] = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_registers();
    reg_data_t data;
    if (app_cmd_ready_o != '0 || app_bits_valid_o != '0 || app_rsp_valid_o != '0 ||
        es_req_o || reg_rvalid_o || intr_cmd_done_o || intr_cmd_err_o) begin
      stop_run("An output is high right after reset");
    end
    reg_read(RegCtrl, data);
    check_reg("ctrl reset value", data, 32'h0);
    reg_read(RegIntrState, data);
    check_reg("intr_state reset value", data, 32'h0);
    reg_read(RegIntrEnable, data);
    check_reg("intr_enable reset value", data, 32'h0);
    reg_write(RegCtrl, 32'h1);
    reg_write(RegIntrEnable, 32'h3);
    reg_read(RegCtrl, data);
    check_reg("ctrl", data, 32'h1);
    reg_read(RegIntrEnable, data);
    check_reg("intr_enable", data, 32'h3);
  endtask

  task automatic test_generate();
    reg_data_t data;
    run_cmd(App0, OpIns, 4'd0, 64'h0123_4567_89ab_cdef, 1'b0);
    // Start from a cleared done bit so that the generate has to raise it
    wait_intr(1'b0);
    reg_write(RegIntrState, 32'h1);
    step();
    if (intr_cmd_done_o) begin
      stop_run("Command done interrupt stayed high after it was cleared");
    end
    run_cmd(App0, OpGen, 4'd5, 64'h0, 1'b0);
    wait_intr(1'b0);
    reg_write(RegIntrState, 32'h1);
    reg_read(RegIntrState, data);
    check_reg("intr_state after clear", data, 32'h0);
  endtask

  task automatic test_errors();
    reg_data_t data;
    run_cmd(App0, 2'd0, 4'd3, 64'h0, 1'b0);
    run_cmd(App0, OpGen, 4'd0, 64'h0, 1'b0);
    run_cmd(App1, OpGen, 4'd4, 64'h0, 1'b0);
    wait_intr(1'b1);
    reg_read(RegIntrState, data);
    check_reg("intr_state after errors", data, 32'h3);
    reg_write(RegIntrState, 32'h3);
    reg_read(RegIntrState, data);
    check_reg("intr_state after clear", data, 32'h0);
  endtask

  task automatic test_concurrent();
    run_cmd(App0, OpIns, 4'd0, 64'hfeed_0000_0000_0a0a, 1'b0);
    run_cmd(App1, OpIns, 4'd0, 64'h0000_beef_1b1b_0000, 1'b0);
    fork
      run_cmd(App0, OpGen, 4'd6, 64'h0, 1'b1);
      run_cmd(App1, OpGen, 4'd9, 64'h0, 1'b1);
    join
  endtask

  task automatic test_uninstantiate();
    run_cmd(App0, OpUni, 4'd0, 64'h0, 1'b0);
    run_cmd(App0, OpGen, 4'd3, 64'h0, 1'b0);
  endtask

  task automatic test_disable();
    reg_write(RegCtrl, 32'h0);
    for (int i = 0; i < 20; i++) begin
      if (app_cmd_ready_o != '0) begin
        stop_run("Command ready is high while the block is disabled");
      end
      step();
    end
  endtask

  // Answers each entropy request after a random delay
  initial begin : entropy_responder
    forever begin
      step();
      if (es_req_o && !es_valid_i) begin
        es_delay = $unsigned($random(seed)) % 5;
        repeat (es_delay) step();
        es_word    = {$random(seed), $random(seed)};
        es_bits_i  = es_word;
        es_valid_i = 1'b1;
        step();
        es_valid_i = 1'b0;
      end
    end
  end

  initial begin : main
    rst_i            = 1'b1;
    app_cmd_valid_i  = '0;
    app_cmd_op_i     = '0;
    app_cmd_glen_i   = '0;
    app_cmd_adata_i  = '0;
    app_bits_ready_i = '0;
    es_valid_i       = 1'b0;
    es_bits_i        = '0;
    es_word          = '0;
    reg_valid_i      = 1'b0;
    reg_write_i      = 1'b0;
    reg_addr_i       = '0;
    reg_wdata_i      = '0;
    for (int a = 0; a < NHwApps; a++) begin
      model_key[a]  = '0;
      model_ctr[a]  = '0;
      model_inst[a] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    step();
    test_registers();
    test_generate();
    test_errors();
    test_concurrent();
    test_uninstantiate();
    test_disable();
    $display("test passed");
    $finish;
  end

endmodule
